// ==== verilog/conv_pkg.sv ====
package conv_pkg;

  localparam int img_dim    = 32;
  localparam int img_pixels = img_dim * img_dim;
  localparam int pos_w      = $clog2(img_dim);      // row or column index
  localparam int buf_len    = 2 * img_dim + 3;      // two lines plus three taps

  localparam int pixel_w    = 8;
  localparam int sum_w      = 13;                   // signed conv sum
  localparam int feat_w     = 12;                   // after relu
  localparam int iaddr_w    = 2 * pos_w;
  localparam int l1_addr_w  = iaddr_w - 2;
  localparam int pipe_depth = 3;

  localparam int kernel_w   = 3;
  // row-major 3x3 filter
  localparam logic signed [kernel_w-1:0] kernel [9] = '{
    -3'sd2,  3'sd0,  3'sd1,
     3'sd0,  3'sd1,  3'sd2,
     3'sd1,  3'sd2, -3'sd3
  };

  typedef logic [pixel_w-1:0] pixel_t;

  typedef struct packed {
    pixel_t p0, p1, p2;   // top row
    pixel_t p3, p4, p5;   // p4 is the centre
    pixel_t p6, p7, p8;
  } window_t;

  typedef struct packed {
    logic top;
    logic bottom;
    logic left;
    logic right;
  } edge_t;

  typedef struct packed {
    logic                 wen;
    logic [iaddr_w-1:0]   addr;
    logic [feat_w-1:0]    data;
  } l0_wr_t;

  typedef struct packed {
    logic                 wen;
    logic [l1_addr_w-1:0] addr;
    logic [feat_w-1:0]    data;
  } l1_wr_t;

endpackage

// ==== verilog/layer_ctrl.sv ====
`timescale 1ns/1ps

module layer_ctrl (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          ready,
  output logic                          busy,
  output logic [conv_pkg::iaddr_w-1:0]  iaddr,
  output logic                          ioe,
  output logic                          shift_en,
  output logic                          flush,
  output logic                          win_valid,
  output conv_pkg::edge_t               win_edge
);

  typedef enum logic [1:0] {st_idle, st_read, st_flush, st_drain} state_t;

  state_t                        state;
  logic [conv_pkg::iaddr_w-1:0]  step_cnt;   // flush length, then drain delay
  logic [conv_pkg::iaddr_w-1:0]  prime_cnt;  // shifts until first full window
  logic [conv_pkg::pos_w-1:0]    cen_row;
  logic [conv_pkg::pos_w-1:0]    cen_col;
  logic                          rd_q;
  logic                          flush_q;
  logic                          start;
  logic                          win_last;

  assign start    = (state == st_idle) && ready;
  assign busy     = (state != st_idle);
  assign ioe      = (state == st_read);
  assign shift_en = rd_q | flush_q;      // one cycle behind ioe, lines up with idata
  assign flush    = flush_q;
  assign win_last = win_valid && (&cen_row) && (&cen_col);

  assign win_edge.top    = (cen_row == '0);
  assign win_edge.bottom = &cen_row;
  assign win_edge.left   = (cen_col == '0);
  assign win_edge.right  = &cen_col;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= st_idle;
      iaddr    <= '0;
      step_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (ready) begin
            state <= st_read;
            iaddr <= '0;
          end
        end
        st_read: begin
          iaddr <= iaddr + 1'b1;
          if (iaddr == conv_pkg::img_pixels - 1) begin
            state    <= st_flush;
            step_cnt <= '0;
          end
        end
        st_flush: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == conv_pkg::img_dim) begin  // img_dim+1 zero shifts
            state    <= st_drain;
            step_cnt <= '0;
          end
        end
        st_drain: begin
          // count out the conv pipe after the last window
          if (win_last || step_cnt != '0)
            step_cnt <= step_cnt + 1'b1;
          if (step_cnt == conv_pkg::pipe_depth)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_q      <= 1'b0;
      flush_q   <= 1'b0;
      win_valid <= 1'b0;
      prime_cnt <= '0;
      cen_row   <= '0;
      cen_col   <= '0;
    end else begin
      rd_q      <= ioe;
      flush_q   <= (state == st_flush);
      win_valid <= shift_en && (prime_cnt == conv_pkg::img_dim + 1);
      if (start) begin
        prime_cnt <= '0;
        cen_row   <= '0;
        cen_col   <= '0;
      end else begin
        if (shift_en && prime_cnt != conv_pkg::img_dim + 1)
          prime_cnt <= prime_cnt + 1'b1;
        if (win_valid) begin
          cen_col <= cen_col + 1'b1;
          if (&cen_col)
            cen_row <= cen_row + 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/window_buffer.sv ====
`timescale 1ns/1ps

module window_buffer (
  input  logic              clk,
  input  logic              shift_en,
  input  logic              flush,
  input  conv_pkg::pixel_t  idata,
  output conv_pkg::window_t window
);

  // sr[0] holds the oldest pixel, new ones enter at the top
  conv_pkg::pixel_t sr [conv_pkg::buf_len];

  always_ff @(posedge clk) begin
    if (shift_en) begin
      for (int i = 0; i < conv_pkg::buf_len - 1; i++)
        sr[i] <= sr[i+1];
      sr[conv_pkg::buf_len-1] <= flush ? '0 : idata;
    end
  end

  // row above
  assign window.p0 = sr[0];
  assign window.p1 = sr[1];
  assign window.p2 = sr[2];

  assign window.p3 = sr[conv_pkg::img_dim];
  assign window.p4 = sr[conv_pkg::img_dim + 1];   // centre
  assign window.p5 = sr[conv_pkg::img_dim + 2];

  // row below, newest pixel last
  assign window.p6 = sr[2 * conv_pkg::img_dim];
  assign window.p7 = sr[2 * conv_pkg::img_dim + 1];
  assign window.p8 = sr[2 * conv_pkg::img_dim + 2];

endmodule

// ==== verilog/conv_pipe.sv ====
`timescale 1ns/1ps

module conv_pipe (
  input  logic              clk,
  input  logic              reset,
  input  logic              win_valid,
  input  conv_pkg::window_t window,
  input  conv_pkg::edge_t   win_edge,
  output conv_pkg::l0_wr_t  l0_wr
);

  // pixel times a 3-bit two's complement weight, shift and add
  function automatic logic signed [conv_pkg::sum_w-1:0] weigh(
    input conv_pkg::pixel_t                    p,
    input logic signed [conv_pkg::kernel_w-1:0] w
  );
    logic signed [conv_pkg::sum_w-1:0] px;
    px = $signed({{(conv_pkg::sum_w - conv_pkg::pixel_w){1'b0}}, p});
    weigh = '0;
    if (w[0]) weigh = weigh + px;
    if (w[1]) weigh = weigh + (px << 1);
    if (w[2]) weigh = weigh - (px << 2);  // sign bit weighs -4
  endfunction

  // tap i lies outside the image for this border set
  function automatic logic outside(input int i, input conv_pkg::edge_t e);
    outside = (e.top && i < 3) || (e.bottom && i > 5) ||
              (e.left && i % 3 == 0) || (e.right && i % 3 == 2);
  endfunction

  conv_pkg::pixel_t                  tap  [9];
  logic signed [conv_pkg::sum_w-1:0] prod [9];
  logic signed [conv_pkg::sum_w-1:0] s1   [5];
  logic signed [conv_pkg::sum_w-1:0] s2   [3];
  logic signed [conv_pkg::sum_w-1:0] s3;
  logic                              v1;
  logic                              v2;
  logic                              v3;
  logic [conv_pkg::iaddr_w-1:0]      l0_addr;

  assign tap = '{window.p0, window.p1, window.p2,
                 window.p3, window.p4, window.p5,
                 window.p6, window.p7, window.p8};

  always_comb begin
    for (int i = 0; i < 9; i++) begin
      if (outside(i, win_edge))
        prod[i] = '0;  // zero padding
      else
        prod[i] = weigh(tap[i], conv_pkg::kernel[i]);
    end
  end

  // adder tree 9 -> 5 -> 3 -> 1
  always_ff @(posedge clk) begin
    for (int k = 0; k < 4; k++)
      s1[k] <= prod[2*k] + prod[2*k+1];
    s1[4] <= prod[8];
    s2[0] <= s1[0] + s1[1];
    s2[1] <= s1[2] + s1[3];
    s2[2] <= s1[4];
    s3    <= s2[0] + s2[1] + s2[2];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      v1      <= 1'b0;
      v2      <= 1'b0;
      v3      <= 1'b0;
      l0_addr <= '0;
    end else begin
      v1 <= win_valid;
      v2 <= v1;
      v3 <= v2;
      if (v3)
        l0_addr <= l0_addr + 1'b1;  // wraps to zero after a full image
    end
  end

  // relu
  assign l0_wr.wen  = v3;
  assign l0_wr.addr = l0_addr;
  assign l0_wr.data = s3[conv_pkg::sum_w-1] ? '0 : s3[conv_pkg::feat_w-1:0];

endmodule

// ==== verilog/max_pool.sv ====
`timescale 1ns/1ps

module max_pool (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         feat_valid,
  input  logic [conv_pkg::feat_w-1:0]  feat,
  output conv_pkg::l1_wr_t             l1_wr
);

  logic [conv_pkg::pos_w-1:0]              col;
  logic [conv_pkg::pos_w-1:0]              row;
  logic [conv_pkg::pos_w-1:0]              col_cur;
  logic [conv_pkg::pos_w-1:0]              row_cur;
  logic [conv_pkg::l1_addr_w-1:0]          l1_addr;
  logic [conv_pkg::l1_addr_w-1:0]          l1_addr_cur;
  logic [$clog2(conv_pkg::pipe_depth + 2)-1:0] gap_cnt;
  logic                                    restart;
  logic [conv_pkg::feat_w-1:0]             left_q;    // even column of the pair
  logic [conv_pkg::feat_w-1:0]             pair_max;
  logic [conv_pkg::feat_w-1:0]             above;
  logic [conv_pkg::feat_w-1:0]             row_max [conv_pkg::img_dim / 2];

  // long idle gap means a new image is starting
  assign restart     = feat_valid && (gap_cnt > conv_pkg::pipe_depth);
  assign col_cur     = restart ? '0 : col;
  assign row_cur     = restart ? '0 : row;
  assign l1_addr_cur = restart ? '0 : l1_addr;

  assign pair_max = (left_q > feat) ? left_q : feat;
  assign above    = row_max[col_cur[conv_pkg::pos_w-1:1]];

  assign l1_wr.wen  = feat_valid && col_cur[0] && row_cur[0];
  assign l1_wr.addr = l1_addr_cur;
  assign l1_wr.data = (above > pair_max) ? above : pair_max;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      col     <= '0;
      row     <= '0;
      l1_addr <= '0;
      gap_cnt <= '1;  // first feature after reset counts as a restart
    end else begin
      if (feat_valid) begin
        gap_cnt <= '0;
        col     <= col_cur + 1'b1;
        row     <= (&col_cur) ? row_cur + 1'b1 : row_cur;
        l1_addr <= l1_wr.wen ? l1_addr_cur + 1'b1 : l1_addr_cur;
      end else if (gap_cnt <= conv_pkg::pipe_depth) begin
        gap_cnt <= gap_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (feat_valid && !col_cur[0])
      left_q <= feat;
    if (feat_valid && col_cur[0] && !row_cur[0])
      row_max[col_cur[conv_pkg::pos_w-1:1]] <= pair_max;  // kept for the row below
  end

endmodule

// ==== verilog/conv_top.sv ====
`timescale 1ns/1ps

module conv_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          ready,
  output logic                          busy,
  output logic [conv_pkg::iaddr_w-1:0]  iaddr,
  output logic                          ioe,
  input  conv_pkg::pixel_t              idata,
  output conv_pkg::l0_wr_t              l0_wr,
  output conv_pkg::l1_wr_t              l1_wr
);

  logic              shift_en;
  logic              flush;
  logic              win_valid;
  conv_pkg::edge_t   win_edge;
  conv_pkg::window_t window;

  layer_ctrl u_layer_ctrl (
    .clk       (clk),
    .reset     (reset),
    .ready     (ready),
    .busy      (busy),
    .iaddr     (iaddr),
    .ioe       (ioe),
    .shift_en  (shift_en),
    .flush     (flush),
    .win_valid (win_valid),
    .win_edge  (win_edge)
  );

  window_buffer u_window_buffer (
    .clk      (clk),
    .shift_en (shift_en),
    .flush    (flush),
    .idata    (idata),
    .window   (window)
  );

  conv_pipe u_conv_pipe (
    .clk       (clk),
    .reset     (reset),
    .win_valid (win_valid),
    .window    (window),
    .win_edge  (win_edge),
    .l0_wr     (l0_wr)
  );

  // pooling taps the layer-0 write stream
  max_pool u_max_pool (
    .clk        (clk),
    .reset      (reset),
    .feat_valid (l0_wr.wen),
    .feat       (l0_wr.data),
    .l1_wr      (l1_wr)
  );

endmodule

// ==== verification/conv_ref_model.svh ====
`ifndef conv_ref_model_svh
`define conv_ref_model_svh

// zero padding outside the image
function automatic int pixel_at(input conv_pkg::pixel_t image [conv_pkg::img_pixels],
                                input int r, input int c);
  if (r < 0 || r >= conv_pkg::img_dim || c < 0 || c >= conv_pkg::img_dim)
    return 0;
  return int'(image[r * conv_pkg::img_dim + c]);
endfunction

// signed 3x3 sum around (r, c), kernel row-major from top left
function automatic int window_sum(input conv_pkg::pixel_t image [conv_pkg::img_pixels],
                                  input int r, input int c);
  int sum;
  sum = 0;
  for (int k = 0; k < 9; k++)
    sum += int'(conv_pkg::kernel[k]) * pixel_at(image, r + k / 3 - 1, c + k % 3 - 1);
  return sum;
endfunction

function automatic int relu(input int s);
  return (s < 0) ? 0 : s;
endfunction

// every positive weight on a 255 pixel
function automatic int max_positive_sum();
  int sum;
  sum = 0;
  for (int k = 0; k < 9; k++)
    if (int'(conv_pkg::kernel[k]) > 0)
      sum += int'(conv_pkg::kernel[k]) * 255;
  return sum;
endfunction

// largest of the 2x2 block behind pooled address blk
function automatic int pool_max(input int feats [conv_pkg::img_pixels], input int blk);
  int half;
  int base;
  int m;
  half = conv_pkg::img_dim / 2;
  base = 2 * (blk / half) * conv_pkg::img_dim + 2 * (blk % half);
  m = feats[base];
  if (feats[base + 1] > m) m = feats[base + 1];
  if (feats[base + conv_pkg::img_dim] > m) m = feats[base + conv_pkg::img_dim];
  if (feats[base + conv_pkg::img_dim + 1] > m) m = feats[base + conv_pkg::img_dim + 1];
  return m;
endfunction

`endif

// ==== verification/conv_tb.sv ====
`timescale 1ns/1ps

module conv_tb;

  `include "conv_ref_model.svh"

  localparam int run_cycles  = conv_pkg::img_pixels + 2 * conv_pkg::img_dim + 20;
  localparam int cycle_limit = 3 * run_cycles + 4;
  localparam int l1_pixels   = conv_pkg::img_pixels / 4;

  logic                          clk;
  logic                          reset;
  logic                          ready;
  logic                          busy;
  logic [conv_pkg::iaddr_w-1:0]  iaddr;
  logic                          ioe;
  conv_pkg::pixel_t              idata;
  conv_pkg::l0_wr_t              l0_wr;
  conv_pkg::l1_wr_t              l1_wr;

  conv_pkg::pixel_t img     [conv_pkg::img_pixels];
  int               exp_l0  [conv_pkg::img_pixels];
  int               rec_l0  [conv_pkg::img_pixels];
  bit               neg_win [conv_pkg::img_pixels];
  int               exp_l1  [l1_pixels];
  int               l0_count;
  int               l1_count;
  int               rd_count;
  int               clamped;
  int               mismatch_errs;
  int               other_errs;
  int               cycle_cnt;
  int               max_feat;
  string            test_name;

  conv_top u_conv_top (
    .clk   (clk),
    .reset (reset),
    .ready (ready),
    .busy  (busy),
    .iaddr (iaddr),
    .ioe   (ioe),
    .idata (idata),
    .l0_wr (l0_wr),
    .l1_wr (l1_wr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // image memory, one cycle read latency
  always @(posedge clk) begin
    if (ioe)
      idata <= img[iaddr];
  end

  assert property (@(posedge clk) disable iff (reset) (l0_wr.wen || l1_wr.wen) |-> busy)
    else begin
      other_errs++;
      $display("%s: write strobe seen while busy was low", test_name);
    end

  assert property (@(posedge clk) disable iff (reset) ioe |-> busy)
    else begin
      other_errs++;
      $display("%s: image read while busy was low", test_name);
    end

  always @(negedge clk) begin : write_monitor
    int addr;
    int data;
    if (!reset && ioe) begin
      assert (int'(iaddr) == rd_count) else begin
        mismatch_errs++;
        $display("Mismatch %s image addr: expected %0d, actual %0d",
                 test_name, rd_count, iaddr);
      end
      rd_count++;
    end
    if (!reset && l0_wr.wen) begin
      addr = int'(l0_wr.addr);
      data = int'(l0_wr.data);
      assert (addr == l0_count) else begin
        mismatch_errs++;
        $display("Mismatch %s l0 addr: expected %0d, actual %0d", test_name, l0_count, addr);
      end
      assert (data == exp_l0[addr]) else begin
        mismatch_errs++;
        $display("Mismatch %s l0[%0d]: expected %0d, actual %0d",
                 test_name, addr, exp_l0[addr], data);
      end
      assert (data <= max_feat) else begin
        other_errs++;
        $display("%s: layer-0 value %0d at %0d is out of range", test_name, data, addr);
      end
      if (neg_win[addr] && data == 0)
        clamped++;  // negative sum stored as zero
      rec_l0[addr] = data;
      l0_count++;
    end
    // after layer 0, the block may complete in this cycle
    if (!reset && l1_wr.wen) begin
      addr = int'(l1_wr.addr);
      data = int'(l1_wr.data);
      assert (addr == l1_count) else begin
        mismatch_errs++;
        $display("Mismatch %s l1 addr: expected %0d, actual %0d", test_name, l1_count, addr);
      end
      assert (data == pool_max(rec_l0, addr)) else begin
        mismatch_errs++;
        $display("Mismatch %s l1[%0d] vs recorded: expected %0d, actual %0d",
                 test_name, addr, pool_max(rec_l0, addr), data);
      end
      assert (data == exp_l1[addr]) else begin
        mismatch_errs++;
        $display("Mismatch %s l1[%0d]: expected %0d, actual %0d",
                 test_name, addr, exp_l1[addr], data);
      end
      l1_count++;
    end
  end

  task automatic print_counts();
    $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
  endtask

  // kind 0 random, 1 all 255, 2 bright border
  task automatic run_image(input int kind, input string name);
    int s;
    int r;
    int c;
    test_name   = name;
    for (int p = 0; p < conv_pkg::img_pixels; p++) begin
      r = p / conv_pkg::img_dim;
      c = p % conv_pkg::img_dim;
      if (kind == 0)
        img[p] = 8'($urandom % 256);
      else if (kind == 1)
        img[p] = 8'hff;
      else
        img[p] = (r == 0 || c == 0 || r == conv_pkg::img_dim - 1 ||
                  c == conv_pkg::img_dim - 1) ? 8'hff : 8'h00;
    end
    for (int p = 0; p < conv_pkg::img_pixels; p++) begin
      s = window_sum(img, p / conv_pkg::img_dim, p % conv_pkg::img_dim);
      neg_win[p] = (s < 0);
      exp_l0[p]  = relu(s);
      rec_l0[p]  = -1;
    end
    for (int b = 0; b < l1_pixels; b++)
      exp_l1[b] = pool_max(exp_l0, b);
    l0_count = 0;
    l1_count = 0;
    rd_count = 0;
    clamped  = 0;

    @(posedge clk);
    ready <= 1'b1;
    @(negedge clk);
    while (!busy) @(negedge clk);
    @(posedge clk);
    ready <= 1'b0;
    @(negedge clk);
    while (busy) @(negedge clk);

    assert (rd_count == conv_pkg::img_pixels) else begin
      mismatch_errs++;
      $display("Mismatch %s image reads: expected %0d, actual %0d",
               name, conv_pkg::img_pixels, rd_count);
    end
    assert (l0_count == conv_pkg::img_pixels) else begin
      mismatch_errs++;
      $display("Mismatch %s l0 writes: expected %0d, actual %0d",
               name, conv_pkg::img_pixels, l0_count);
    end
    assert (l1_count == l1_pixels) else begin
      mismatch_errs++;
      $display("Mismatch %s l1 writes: expected %0d, actual %0d", name, l1_pixels, l1_count);
    end
    if (kind != 1) begin
      assert (clamped > 0) else begin
        other_errs++;
        $display("%s: no window with a negative sum was stored as zero", name);
      end
    end
    repeat (2) @(posedge clk);
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    print_counts();
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h89fe));
    reset         = 1'b1;
    ready         = 1'b0;
    idata         = '0;
    mismatch_errs = 0;
    other_errs    = 0;
    l0_count      = 0;
    l1_count      = 0;
    rd_count      = 0;
    clamped       = 0;
    test_name     = "reset";
    max_feat      = max_positive_sum();

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      assert (!busy && !ioe && !l0_wr.wen && !l1_wr.wen) else begin
        other_errs++;
        $display("outputs not idle after reset");
      end
    end

    run_image(0, "random");
    run_image(1, "all_255");
    run_image(2, "border");

    print_counts();
    if (mismatch_errs == 0 && other_errs == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+verification
verilog/conv_pkg.sv
verilog/layer_ctrl.sv
verilog/window_buffer.sv
verilog/conv_pipe.sv
verilog/max_pool.sv
verilog/conv_top.sv
verification/conv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build conv_tb with Verilator, run it, then scan the log

top=conv_tb
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module "$top" -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$log"; then
  exit 1
fi
exit 0
